/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_fetch \
    -f verilog.f \
    -o sim_fetch

output=$(./obj_dir/sim_fetch 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "Simulation passed"; then
    exit 0
else
    exit 1
fi

/* sim/tb_fetch.sv */
`timescale 1ns/1ps

module tb_fetch;

    import fetch_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int STIM_CYCLES = 6000;
    localparam int TIMEOUT_CYCLES = STIM_CYCLES + STIM_CYCLES / 3;
    localparam int FLUSH_START = 20;
    localparam int DRAIN_PACKETS = 32;
    localparam int MIN_PACKETS = 500;
    localparam int MIN_FLUSHES = 200;
    localparam int MIN_STALLS = 200;
    localparam logic [31:0] INST_XOR = 32'h5a5a0000;
    localparam int unsigned REDIRECT_WORDS = 256;

    logic           clk;
    logic           prev_rst;
    logic           backend_flush;
    logic [31:0]    backend_redirect_pc;
    fetch_packet_t  deq_packet;
    logic           deq_valid;
    logic           deq_ready;
    mem_req_t       mem_req;
    mem_resp_t      mem_resp;

    // memory responder state
    logic           mem_busy;
    int             mem_wait;
    logic [31:0]    mem_addr;

    // line addresses the cache should hold, one per set
    logic [31:0]    model_line [ICACHE_SETS];
    logic           model_valid [ICACHE_SETS];

    logic [31:0]    expected_pc;
    int             packets_checked;
    int             flush_count;
    int             stall_count;
    int             cycle_count = 0;

    fetch_subsystem fetch_subsystem_i (
        .clk                 (clk),
        .prev_rst            (prev_rst),
        .backend_flush       (backend_flush),
        .backend_redirect_pc (backend_redirect_pc),
        .deq_packet          (deq_packet),
        .deq_valid           (deq_valid),
        .deq_ready           (deq_ready),
        .mem_req             (mem_req),
        .mem_resp            (mem_resp)
    );

    always #50 clk = ~clk;

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("error: %s expected %h actual %h", name, expected, actual));
        end
    endtask

    function automatic logic [31:0] block_base(input logic [31:0] addr);
        return addr - (addr % IF_BLK_BYTES);
    endfunction

    // memory content rule, every word encodes its own address
    function automatic logic [31:0] inst_at(input logic [31:0] addr);
        return addr ^ INST_XOR;
    endfunction

    function automatic logic [SET_IDX_BITS-1:0] line_set(input logic [31:0] addr);
        return SET_IDX_BITS'(addr / LINE_BYTES);
    endfunction

    function automatic logic line_held(input logic [31:0] line_addr);
        return model_valid[line_set(line_addr)] && (model_line[line_set(line_addr)] == line_addr);
    endfunction

    task automatic serve_memory();
        logic [LINE_BITS-1:0] line_bits;
        mem_resp.resp = 1'b0;
        if (mem_busy) begin
            check_value("mem_req hold read", 32'd1, 32'(mem_req.read));
            check_value("mem_req hold addr", mem_addr, mem_req.addr);
            if (mem_wait > 1) begin
                mem_wait--;
            end else begin
                for (int k = 0; k < int'(LINE_WORDS); k++) begin
                    line_bits[32*k +: 32] = inst_at(mem_addr + 32'(4 * k));
                end
                mem_resp.rdata = line_bits;
                mem_resp.resp = 1'b1;
                model_line[line_set(mem_addr)] = mem_addr;
                model_valid[line_set(mem_addr)] = 1'b1;
                mem_busy = 1'b0;
            end
        end else if (mem_req.read) begin
            check_value("mem_req alignment", 32'd0, mem_req.addr % LINE_BYTES);
            check_value("mem_req to held line", 32'd0, 32'(line_held(mem_req.addr)));
            mem_addr = mem_req.addr;
            mem_wait = 1 + int'($urandom % 6);
            mem_busy = 1'b1;
        end
    endtask

    task automatic drive_inputs(input bit stim_on, input bit flush_on);
        backend_flush = 1'b0;
        if (stim_on) begin
            deq_ready = ($urandom % 2) == 0;
        end else begin
            deq_ready = 1'b1;
        end
        if (flush_on && ($urandom % 16) == 0) begin
            backend_flush = 1'b1;
            backend_redirect_pc = RESET_PC + 32'(4 * ($urandom % REDIRECT_WORDS));
            flush_count++;
        end
        if (deq_valid && !deq_ready) begin
            stall_count++;
        end
    endtask

    // deq_valid and deq_packet are registered, so the transfer at the next edge is known now
    task automatic check_dequeue();
        if (deq_valid && deq_ready) begin
            check_value("packet pc", expected_pc, deq_packet.pc);
            for (int i = 0; i < int'(IF_WIDTH); i++) begin
                check_value($sformatf("inst[%0d]", i),
                            inst_at(block_base(expected_pc) + 32'(4 * i)),
                            deq_packet.inst[i]);
                check_value($sformatf("predict_target[%0d]", i),
                            expected_pc + 32'(4 * i + 4),
                            deq_packet.predict_target[i]);
            end
            check_value("predict_taken", 32'd0, 32'(deq_packet.predict_taken));
            check_value("slot valid", 32'((1 << IF_WIDTH) - 1), 32'(deq_packet.valid));
            expected_pc = block_base(expected_pc + 32'(IF_BLK_BYTES));
            packets_checked++;
        end
        // everything behind the packet taken this cycle belongs to the old path
        if (backend_flush) begin
            expected_pc = backend_redirect_pc;
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
        end
    end

    initial begin
        int drain_target;
        void'($urandom(9963));
        clk = 1'b0;
        prev_rst = 1'b1;
        backend_flush = 1'b0;
        backend_redirect_pc = '0;
        deq_ready = 1'b0;
        mem_resp = '0;
        mem_busy = 1'b0;
        mem_wait = 0;
        mem_addr = '0;
        for (int s = 0; s < int'(ICACHE_SETS); s++) begin
            model_line[s] = '0;
            model_valid[s] = 1'b0;
        end
        expected_pc = RESET_PC;
        packets_checked = 0;
        flush_count = 0;
        stall_count = 0;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        check_value("deq_valid in reset", 32'd0, 32'(deq_valid));
        check_value("mem_req read in reset", 32'd0, 32'(mem_req.read));
        prev_rst = 1'b0;

        for (int cyc = 0; cyc < STIM_CYCLES; cyc++) begin
            serve_memory();
            drive_inputs(1'b1, cyc >= FLUSH_START);
            check_dequeue();
            @(negedge clk);
        end

        // let a few more blocks through without flushes or stalls
        drain_target = packets_checked + DRAIN_PACKETS;
        while (packets_checked < drain_target) begin
            serve_memory();
            drive_inputs(1'b0, 1'b0);
            check_dequeue();
            @(negedge clk);
        end
        deq_ready = 1'b0;

        $display("packets %0d, flushes %0d, stalls %0d", packets_checked, flush_count,
                 stall_count);
        if (packets_checked < MIN_PACKETS || flush_count < MIN_FLUSHES
                || stall_count < MIN_STALLS) begin
            fail_run("too few packets, flushes or stalls during the run");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

/* src/fetch_pkg.sv */
package fetch_pkg;

    // fetch block geometry
    localparam int unsigned IF_WIDTH = 2;
    localparam int unsigned IF_BLK_BYTES = IF_WIDTH * 4;
    localparam int unsigned BLK_OFF_BITS = $clog2(IF_BLK_BYTES);

    localparam logic [31:0] RESET_PC = 32'h1eceb000;

    // instruction cache geometry
    localparam int unsigned LINE_BYTES = 32;
    localparam int unsigned LINE_WORDS = LINE_BYTES / 4;
    localparam int unsigned LINE_BITS = LINE_BYTES * 8;
    localparam int unsigned LINE_OFF_BITS = $clog2(LINE_BYTES);
    localparam int unsigned BLK_PER_LINE = LINE_WORDS / IF_WIDTH;
    localparam int unsigned BLK_SEL_BITS = $clog2(BLK_PER_LINE);
    localparam int unsigned ICACHE_SETS = 16;
    localparam int unsigned SET_IDX_BITS = $clog2(ICACHE_SETS);
    localparam int unsigned TAG_BITS = 32 - SET_IDX_BITS - LINE_OFF_BITS;

    // fetch queue
    localparam int unsigned QUEUE_DEPTH = 8;
    localparam int unsigned QPTR_BITS = $clog2(QUEUE_DEPTH);

    typedef logic [IF_WIDTH-1:0][31:0] inst_blk_t;

    // word k of a line sits at bits [32k+31:32k]
    typedef inst_blk_t [BLK_PER_LINE-1:0] line_t;

    typedef struct packed {
        logic [31:0]               pc;
        inst_blk_t                 inst;
        logic [IF_WIDTH-1:0]       predict_taken;
        logic [IF_WIDTH-1:0][31:0] predict_target;
        logic [IF_WIDTH-1:0]       valid;
    } fetch_packet_t;

    typedef struct packed {
        logic        read;
        logic [31:0] addr;
    } mem_req_t;

    typedef struct packed {
        logic  resp;
        line_t rdata;
    } mem_resp_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
    } icache_req_t;

    typedef struct packed {
        logic      hit_valid;
        inst_blk_t insts;
    } icache_resp_t;

endpackage

/* src/fetch_queue.sv */
`timescale 1ns/1ps

module fetch_queue (
    input  logic                        clk,
    input  logic                        prev_rst,

    input  logic                        flush,

    input  fetch_pkg::fetch_packet_t    enq_packet,
    input  logic                        enq_valid,
    output logic                        enq_ready,

    output fetch_pkg::fetch_packet_t    deq_packet,
    output logic                        deq_valid,
    input  logic                        deq_ready
);

    import fetch_pkg::*;

    localparam logic [QPTR_BITS:0] FULL_COUNT = (QPTR_BITS + 1)'(QUEUE_DEPTH);

    fetch_packet_t          mem_q   [QUEUE_DEPTH];
    logic [QPTR_BITS-1:0]   wr_ptr;
    logic [QPTR_BITS-1:0]   rd_ptr;
    logic [QPTR_BITS:0]     count;

    logic                   full;
    logic                   enq_fire;
    logic                   deq_fire;

    assign full      = (count == FULL_COUNT);
    assign enq_ready = !full;
    assign deq_valid = (count != '0);

    assign enq_fire = enq_valid && enq_ready;
    assign deq_fire = deq_valid && deq_ready;

    always_ff @(posedge clk) begin
        if (prev_rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (enq_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (deq_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + {QPTR_BITS'(0), enq_fire} - {QPTR_BITS'(0), deq_fire};
        end
    end

    always_ff @(posedge clk) begin
        if (enq_fire) begin
            mem_q[wr_ptr] <= enq_packet;
        end
    end

    assign deq_packet = mem_q[rd_ptr];

    assert property (@(posedge clk) disable iff (prev_rst) count <= FULL_COUNT);

    // an enqueue lands on the first free slot behind the unread entries
    assert property (@(posedge clk) disable iff (prev_rst)
        enq_fire |-> (wr_ptr == rd_ptr + count[QPTR_BITS-1:0]));

endmodule

/* src/fetch_subsystem.sv */
`timescale 1ns/1ps

module fetch_subsystem (
    input  logic                        clk,
    input  logic                        prev_rst,

    input  logic                        backend_flush,
    input  logic [31:0]                 backend_redirect_pc,

    output fetch_pkg::fetch_packet_t    deq_packet,
    output logic                        deq_valid,
    input  logic                        deq_ready,

    output fetch_pkg::mem_req_t         mem_req,
    input  fetch_pkg::mem_resp_t        mem_resp
);

    import fetch_pkg::*;

    icache_req_t    cache_req;
    icache_resp_t   cache_resp;
    fetch_packet_t  enq_packet;
    logic           enq_valid;
    logic           enq_ready;

    frontend_top frontend_top_i (
        .clk                 (clk),
        .prev_rst            (prev_rst),
        .backend_flush       (backend_flush),
        .backend_redirect_pc (backend_redirect_pc),
        .cache_req           (cache_req),
        .cache_resp          (cache_resp),
        .enq_packet          (enq_packet),
        .enq_valid           (enq_valid),
        .enq_ready           (enq_ready)
    );

    icache icache_i (
        .clk        (clk),
        .prev_rst   (prev_rst),
        .flush      (backend_flush),
        .cache_req  (cache_req),
        .cache_resp (cache_resp),
        .mem_req    (mem_req),
        .mem_resp   (mem_resp)
    );

    fetch_queue fetch_queue_i (
        .clk        (clk),
        .prev_rst   (prev_rst),
        .flush      (backend_flush),
        .enq_packet (enq_packet),
        .enq_valid  (enq_valid),
        .enq_ready  (enq_ready),
        .deq_packet (deq_packet),
        .deq_valid  (deq_valid),
        .deq_ready  (deq_ready)
    );

endmodule

/* src/frontend_top.sv */
`timescale 1ns/1ps

module frontend_top (
    input  logic                        clk,
    input  logic                        prev_rst,

    input  logic                        backend_flush,
    input  logic [31:0]                 backend_redirect_pc,

    output fetch_pkg::icache_req_t      cache_req,
    input  fetch_pkg::icache_resp_t     cache_resp,

    output fetch_pkg::fetch_packet_t    enq_packet,
    output logic                        enq_valid,
    input  logic                        enq_ready
);

    import fetch_pkg::*;

    localparam logic [31:0] BLK_MASK = ~32'(IF_BLK_BYTES - 1);

    logic           rst_d;
    logic [31:0]    pc_next;
    logic [31:0]    pc;
    inst_blk_t      insts;
    logic           if1_valid;

    always_ff @(posedge clk) begin
        rst_d <= prev_rst;
    end

    // next fetch block address
    always_comb begin
        if (rst_d) begin
            pc_next = RESET_PC;
        end else if (backend_flush) begin
            pc_next = backend_redirect_pc;
        end else begin
            pc_next = (pc + 32'(IF_BLK_BYTES)) & BLK_MASK;
        end
    end

    if1_stage if1_stage_i (
        .clk        (clk),
        .prev_rst   (prev_rst),
        .flush      (backend_flush),
        .nxt_valid  (if1_valid),
        .nxt_ready  (enq_ready),
        .pc_next    (pc_next),
        .pc         (pc),
        .insts      (insts),
        .cache_req  (cache_req),
        .cache_resp (cache_resp)
    );

    assign enq_valid = if1_valid;

    assign enq_packet.pc            = pc;
    assign enq_packet.inst          = insts;
    assign enq_packet.predict_taken = '0;
    assign enq_packet.valid         = '1;

    // no predictor yet, every slot falls through
    for (genvar i = 0; i < IF_WIDTH; i++) begin : g_target
        assign enq_packet.predict_target[i] = pc + 32'(i) * 32'd4 + 32'd4;
    end

endmodule

/* src/icache.sv */
`timescale 1ns/1ps

module icache (
    input  logic                    clk,
    input  logic                    prev_rst,

    input  logic                    flush,

    input  fetch_pkg::icache_req_t  cache_req,
    output fetch_pkg::icache_resp_t cache_resp,

    output fetch_pkg::mem_req_t     mem_req,
    input  fetch_pkg::mem_resp_t    mem_resp
);

    import fetch_pkg::*;

    typedef enum logic {
        ST_IDLE,
        ST_REFILL
    } state_t;

    state_t                     state;

    logic   [TAG_BITS-1:0]      tag_q   [ICACHE_SETS];
    line_t                      data_q  [ICACHE_SETS];
    logic   [ICACHE_SETS-1:0]   valid_q;

    logic   [31:0]              refill_addr_q;
    logic                       refill_live_q;

    logic                       hit_valid_q;
    inst_blk_t                  insts_q;

    logic   [SET_IDX_BITS-1:0]  req_idx;
    logic   [TAG_BITS-1:0]      req_tag;
    logic   [BLK_SEL_BITS-1:0]  req_blk;
    logic                       lookup;
    logic                       hit;

    logic   [SET_IDX_BITS-1:0]  refill_idx;
    logic   [TAG_BITS-1:0]      refill_tag;
    logic   [BLK_SEL_BITS-1:0]  refill_blk;
    logic                       refill_done;

    assign req_idx = cache_req.addr[LINE_OFF_BITS +: SET_IDX_BITS];
    assign req_tag = cache_req.addr[31 -: TAG_BITS];
    assign req_blk = cache_req.addr[BLK_OFF_BITS +: BLK_SEL_BITS];

    assign refill_idx = refill_addr_q[LINE_OFF_BITS +: SET_IDX_BITS];
    assign refill_tag = refill_addr_q[31 -: TAG_BITS];
    assign refill_blk = refill_addr_q[BLK_OFF_BITS +: BLK_SEL_BITS];

    // new requests are only looked at while no refill runs
    assign lookup = (state == ST_IDLE) && cache_req.valid;
    assign hit = valid_q[req_idx] && (tag_q[req_idx] == req_tag);
    assign refill_done = (state == ST_REFILL) && mem_resp.resp;

    always_ff @(posedge clk) begin
        if (prev_rst) begin
            state         <= ST_IDLE;
            valid_q       <= '0;
            refill_live_q <= 1'b0;
            hit_valid_q   <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    hit_valid_q <= lookup && hit;
                    if (lookup && !hit) begin
                        state         <= ST_REFILL;
                        refill_live_q <= 1'b1;
                    end
                end
                ST_REFILL: begin
                    // a refill from a flushed path fills the line but answers nobody
                    hit_valid_q <= mem_resp.resp && refill_live_q && !flush;
                    if (flush) begin
                        refill_live_q <= 1'b0;
                    end
                    if (mem_resp.resp) begin
                        state               <= ST_IDLE;
                        valid_q[refill_idx] <= 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (lookup && !hit) begin
            refill_addr_q <= cache_req.addr;
        end
        if (refill_done) begin
            tag_q[refill_idx]  <= refill_tag;
            data_q[refill_idx] <= mem_resp.rdata;
            insts_q            <= mem_resp.rdata[refill_blk];
        end else if (lookup) begin
            insts_q <= data_q[req_idx][req_blk];
        end
    end

    assign cache_resp.hit_valid = hit_valid_q;
    assign cache_resp.insts     = insts_q;

    assign mem_req.read = (state == ST_REFILL);
    assign mem_req.addr = {refill_addr_q[31:LINE_OFF_BITS], LINE_OFF_BITS'(0)};

    // the memory side may only answer the single read in flight
    assert property (@(posedge clk) disable iff (prev_rst)
        mem_resp.resp |-> $past(mem_req.read) && mem_req.read);

endmodule

/* src/if1_stage.sv */
`timescale 1ns/1ps

module if1_stage (
    input  logic                    clk,
    input  logic                    prev_rst,

    input  logic                    flush,

    output logic                    nxt_valid,
    input  logic                    nxt_ready,

    input  logic [31:0]             pc_next,

    output logic [31:0]             pc,
    output fetch_pkg::inst_blk_t    insts,

    output fetch_pkg::icache_req_t  cache_req,
    input  fetch_pkg::icache_resp_t cache_resp
);

    import fetch_pkg::*;

    logic       start_q;
    logic       pending_q;
    logic       held_q;
    inst_blk_t  insts_q;

    logic       launch;
    logic       take_hit;

    // a new fetch address is taken on the first cycle out of reset,
    // on a flush, or once the current block has been handed on
    assign launch = start_q || flush || (nxt_valid && nxt_ready);

    assign take_hit = pending_q && cache_resp.hit_valid;

    always_ff @(posedge clk) begin
        if (prev_rst) begin
            start_q   <= 1'b1;
            pending_q <= 1'b0;
            held_q    <= 1'b0;
        end else begin
            start_q <= 1'b0;
            if (launch) begin
                pending_q <= 1'b1;
                held_q    <= 1'b0;
            end else if (take_hit) begin
                // stalled by the consumer, keep the block locally
                pending_q <= 1'b0;
                held_q    <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            pc <= pc_next;
        end
        if (!launch && take_hit) begin
            insts_q <= cache_resp.insts;
        end
    end

    // hit data passes straight through on the cycle it arrives
    assign nxt_valid = held_q || take_hit;
    assign insts     = held_q ? insts_q : cache_resp.insts;

    // keep asking until the cache answers, the cache ignores it while refilling
    assign cache_req.valid = launch || (pending_q && !cache_resp.hit_valid);
    assign cache_req.addr  = launch ? pc_next : pc;

    assert property (@(posedge clk) disable iff (prev_rst)
        (nxt_valid && !nxt_ready && !flush)
            |=> (nxt_valid && $stable(pc) && $stable(insts)));

endmodule

/* verilog.f */
src/fetch_pkg.sv
src/icache.sv
src/if1_stage.sv
src/frontend_top.sv
src/fetch_queue.sv
src/fetch_subsystem.sv
sim/tb_fetch.sv
